/* logic/mmuPkg.sv */
package mmuPkg;

  typedef logic [31:0] memWord;
  typedef logic [31:0] memAddress;

  // Cache line addressing, one word per line
  typedef logic [3:0] cacheIndex;   // address[5:2]
  typedef logic [25:0] cacheTag;    // address[31:6]

  typedef logic [9:0] ramIndex;     // address[11:2]

  typedef logic [5:0] ledValue;
  typedef logic [7:0] matrixByte;
  typedef logic [2:0] matrixRowIndex;

  typedef enum logic [1:0] {
    Idle,
    Fill,
    WriteThrough,
    Uncached
  } cacheState;

  localparam int cacheLines = 16;
  localparam int ramWords = 1024;

  // Peripheral region, address bit 31 set
  localparam memAddress ledAddress = 32'h8000_0000;
  localparam memAddress buttonAddress = 32'h8000_0004;
  localparam memAddress matrixLowAddress = 32'h8000_0008;   // Rows 0 to 3
  localparam memAddress matrixHighAddress = 32'h8000_000C;  // Rows 4 to 7

  // Cycles per lit matrix row
  localparam int scanCycles = 4;
  localparam int scanCountWidth = $clog2(scanCycles);

endpackage

/* logic/memoryBus.sv */
interface memoryBus;

  import mmuPkg::*;

  memAddress address;
  memWord writeData;
  logic readEnable;
  logic writeEnable;

  // Driven by the memory handler
  memWord readData;
  logic ready;   // One cycle, one clock after the request is sampled

  modport cache (
    output address,
    output writeData,
    output readEnable,
    output writeEnable,
    input readData,
    input ready
  );

  modport memory (
    input address,
    input writeData,
    input readEnable,
    input writeEnable,
    output readData,
    output ready
  );

endinterface

/* logic/LedMatrixDriver.sv */
module LedMatrixDriver (
  input logic clk,
  input logic rst,
  input logic frameWrite,
  input logic frameHigh,
  input mmuPkg::memWord frameData,
  output mmuPkg::matrixByte ledMatrixRow,
  output mmuPkg::matrixByte ledMatrixColumn
);

  import mmuPkg::*;

  memWord frameLow;     // Rows 0 to 3
  memWord frameUpper;   // Rows 4 to 7
  logic [scanCountWidth-1:0] scanCount;
  matrixRowIndex rowIndex;
  logic [63:0] frame;

  always_ff @(posedge clk) begin
    if (rst) begin
      frameLow <= '0;
      frameUpper <= '0;
    end else if (frameWrite) begin
      if (frameHigh) begin
        frameUpper <= frameData;
      end else begin
        frameLow <= frameData;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      scanCount <= '0;
      rowIndex <= '0;
    end else if (scanCount == scanCountWidth'(scanCycles - 1)) begin
      scanCount <= '0;
      rowIndex <= rowIndex + 1'b1;   // Wraps 7 to 0
    end else begin
      scanCount <= scanCount + 1'b1;
    end
  end

  assign frame = {frameUpper, frameLow};
  assign ledMatrixRow = matrixByte'(1) << rowIndex;
  assign ledMatrixColumn = frame[rowIndex*8 +: 8];

  // Each row stays lit for scanCycles cycles
  rowHoldTime: assert property (
    @(posedge clk) disable iff (rst)
    (rowIndex != $past(rowIndex)) |-> ($past(rowIndex) == $past(rowIndex, scanCycles))
  );

endmodule

/* logic/CacheL1.sv */
module CacheL1 #(
  parameter bit readOnly = 1'b0
) (
  input logic clk,
  input logic rst,
  input logic readEnable,
  input logic writeEnable,
  input mmuPkg::memAddress address,
  input mmuPkg::memWord dataIn,
  output mmuPkg::memWord dataOut,
  output logic success,
  memoryBus.cache mem
);

  import mmuPkg::*;

  memWord dataArray [cacheLines];
  cacheTag tagArray [cacheLines];
  logic [cacheLines-1:0] validBits;

  cacheState state;
  cacheState nextState;

  cacheIndex lineIndex;
  cacheTag lineTag;
  logic uncachedTarget;
  logic writeRequest;
  logic readRequest;
  logic hit;
  logic memRequest;
  logic fillDone;

  assign lineIndex = address[5:2];
  assign lineTag = address[31:6];
  assign uncachedTarget = address[31];   // Peripheral region

  // Writes never reach a read-only cache
  assign writeRequest = !readOnly && writeEnable;
  assign readRequest = readEnable && !writeRequest;

  assign hit = validBits[lineIndex] && (tagArray[lineIndex] == lineTag);

  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (uncachedTarget && (readRequest || writeRequest)) begin
          nextState = Uncached;
        end else if (writeRequest) begin
          nextState = WriteThrough;
        end else if (readRequest && !hit) begin
          nextState = Fill;
        end
      end
      Fill, WriteThrough, Uncached: begin
        if (mem.ready) begin
          nextState = Idle;
        end
      end
      default: nextState = Idle;
    endcase
  end

  // Request goes out in the Idle cycle, held until ready
  assign memRequest = ((state == Idle) && (nextState != Idle)) ||
                      ((state != Idle) && !mem.ready);

  assign mem.address = address;
  assign mem.writeData = readOnly ? '0 : dataIn;
  assign mem.readEnable = memRequest && readRequest;
  assign mem.writeEnable = memRequest && writeRequest;

  assign fillDone = (state == Fill) && mem.ready;

  // A filled line answers as a hit once back in Idle
  assign success = ((state == Idle) && readRequest && !uncachedTarget && hit) ||
                   ((state == WriteThrough || state == Uncached) && mem.ready);

  assign dataOut = (state == Uncached) ? mem.readData : dataArray[lineIndex];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= Idle;
      validBits <= '0;
    end else begin
      state <= nextState;
      if (fillDone) begin
        validBits[lineIndex] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fillDone) begin
      dataArray[lineIndex] <= mem.readData;
      tagArray[lineIndex] <= lineTag;
    end else if ((state == WriteThrough) && mem.ready && hit) begin
      dataArray[lineIndex] <= dataIn;   // No allocation on a write miss
    end
  end

  // Handler answers only an outstanding request
  readyWhileWaiting: assert property (
    @(posedge clk) disable iff (rst)
    mem.ready |-> (state != Idle)
  );

  // Requester must hold the address until the handler answers
  stableAddress: assert property (
    @(posedge clk) disable iff (rst)
    (mem.readEnable || mem.writeEnable) |=> $stable(mem.address)
  );

endmodule

/* logic/MemoryHandler.sv */
module MemoryHandler (
  input logic clk,
  input logic rst,
  input logic button,
  output mmuPkg::ledValue led,
  memoryBus.memory instrBus,
  memoryBus.memory dataBus,
  output mmuPkg::matrixByte ledMatrixRow,
  output mmuPkg::matrixByte ledMatrixColumn
);

  import mmuPkg::*;

  memWord ram [ramWords];

  ramIndex instrIndex;
  ramIndex dataIndex;
  memWord instrRead;
  memWord dataRead;
  memWord peripheralRead;
  logic instrReady;
  logic dataReady;
  logic dataPeripheral;
  logic dataWrite;
  logic [1:0] buttonSync;
  ledValue ledRegister;
  logic frameWrite;
  logic frameHigh;

  assign instrIndex = instrBus.address[11:2];
  assign dataIndex = dataBus.address[11:2];
  assign dataPeripheral = dataBus.address[31];
  assign dataWrite = dataBus.writeEnable;

  always_comb begin
    case (dataBus.address)
      ledAddress: peripheralRead = memWord'(ledRegister);
      buttonAddress: peripheralRead = memWord'(buttonSync[1]);
      default: peripheralRead = '0;   // Matrix is write only
    endcase
  end

  assign frameHigh = dataBus.address == matrixHighAddress;
  assign frameWrite = dataWrite && (frameHigh || dataBus.address == matrixLowAddress);

  // Instruction port, read only
  always_ff @(posedge clk) begin
    if (instrBus.readEnable) begin
      instrRead <= instrBus.address[31] ? '0 : ram[instrIndex];
    end
  end

  always_ff @(posedge clk) begin
    if (dataWrite && !dataPeripheral) begin
      ram[dataIndex] <= dataBus.writeData;
    end
    if (dataBus.readEnable) begin
      dataRead <= dataPeripheral ? peripheralRead : ram[dataIndex];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      instrReady <= 1'b0;
      dataReady <= 1'b0;
      buttonSync <= '0;
      ledRegister <= '0;
    end else begin
      instrReady <= instrBus.readEnable || instrBus.writeEnable;
      dataReady <= dataBus.readEnable || dataBus.writeEnable;
      buttonSync <= {buttonSync[0], button};   // Two flop synchronizer
      if (dataWrite && dataBus.address == ledAddress) begin
        ledRegister <= dataBus.writeData[5:0];
      end
    end
  end

  assign instrBus.readData = instrRead;
  assign instrBus.ready = instrReady;
  assign dataBus.readData = dataRead;
  assign dataBus.ready = dataReady;
  assign led = ledRegister;

  LedMatrixDriver matrixDriver_i (
    .clk(clk),
    .rst(rst),
    .frameWrite(frameWrite),
    .frameHigh(frameHigh),
    .frameData(dataBus.writeData),
    .ledMatrixRow(ledMatrixRow),
    .ledMatrixColumn(ledMatrixColumn)
  );

  // Ready lasts one cycle
  instrReadyPulse: assert property (
    @(posedge clk) disable iff (rst)
    instrBus.ready |=> !instrBus.ready
  );

  dataReadyPulse: assert property (
    @(posedge clk) disable iff (rst)
    dataBus.ready |=> !dataBus.ready
  );

endmodule

/* logic/Mmu.sv */
module Mmu (
  input logic clk,
  input logic rst,
  input logic dataMemoryWriteEnable,
  input logic dataMemoryReadEnable,
  input mmuPkg::memAddress dataMemoryAddress,
  input mmuPkg::memWord dataMemoryDataIn,
  output mmuPkg::memWord dataMemoryDataOut,
  output logic dataMemorySuccess,
  input logic instructionMemoryReadEnable,
  input mmuPkg::memAddress instructionMemoryAddress,
  output mmuPkg::memWord instructionMemoryDataOut,
  output logic instructionMemorySuccess,

  // Peripherals
  input logic button,
  output mmuPkg::ledValue led,
  output mmuPkg::matrixByte ledMatrixRow,
  output mmuPkg::matrixByte ledMatrixColumn
);

  memoryBus instructionBus ();
  memoryBus dataBus ();

  CacheL1 #(
    .readOnly(1'b1)
  ) instructionCache_i (
    .clk(clk),
    .rst(rst),
    .readEnable(instructionMemoryReadEnable),
    .writeEnable(1'b0),   // Write side unused when read only
    .address(instructionMemoryAddress),
    .dataIn('0),
    .dataOut(instructionMemoryDataOut),
    .success(instructionMemorySuccess),
    .mem(instructionBus.cache)
  );

  CacheL1 #(
    .readOnly(1'b0)
  ) dataCache_i (
    .clk(clk),
    .rst(rst),
    .readEnable(dataMemoryReadEnable),
    .writeEnable(dataMemoryWriteEnable),
    .address(dataMemoryAddress),
    .dataIn(dataMemoryDataIn),
    .dataOut(dataMemoryDataOut),
    .success(dataMemorySuccess),
    .mem(dataBus.cache)
  );

  // Dual ported RAM, so no arbitration between the caches
  MemoryHandler memoryHandler_i (
    .clk(clk),
    .rst(rst),
    .button(button),
    .led(led),
    .instrBus(instructionBus.memory),
    .dataBus(dataBus.memory),
    .ledMatrixRow(ledMatrixRow),
    .ledMatrixColumn(ledMatrixColumn)
  );

endmodule

/* verification/MmuTb.sv */
module MmuTb;

  import mmuPkg::*;

  localparam bit dataPort = 1'b0;
  localparam bit instrPort = 1'b1;
  localparam logic [1:0] opWrite = 2'd0;
  localparam logic [1:0] opRead = 2'd1;
  localparam logic [1:0] opButton = 2'd2;   // Set button level, hold it, then read it
  localparam int resetCycles = 16;
  localparam int accessLimit = 12;
  localparam int buttonHold = 4;

  typedef struct packed {
    logic isInstr;
    logic [1:0] op;
    memAddress address;
    memWord writeData;
    memWord expected;
  } tableEntry;

  logic clk;
  logic rst;
  logic dataMemoryWriteEnable;
  logic dataMemoryReadEnable;
  memAddress dataMemoryAddress;
  memWord dataMemoryDataIn;
  memWord dataMemoryDataOut;
  logic dataMemorySuccess;
  logic instructionMemoryReadEnable;
  memAddress instructionMemoryAddress;
  memWord instructionMemoryDataOut;
  logic instructionMemorySuccess;
  logic button;
  ledValue led;
  matrixByte ledMatrixRow;
  matrixByte ledMatrixColumn;

  tableEntry entries [$];
  memWord refRam [ramWords];   // Reference RAM, word indexed
  ledValue shadowLed;
  logic buttonModel;
  matrixByte expectedRows [8];
  integer seed;
  int valueErrors = 0;
  int otherErrors = 0;
  int cycleCount = 0;
  int cycleLimit = 0;

  Mmu dut_i (
    .clk(clk),
    .rst(rst),
    .dataMemoryWriteEnable(dataMemoryWriteEnable),
    .dataMemoryReadEnable(dataMemoryReadEnable),
    .dataMemoryAddress(dataMemoryAddress),
    .dataMemoryDataIn(dataMemoryDataIn),
    .dataMemoryDataOut(dataMemoryDataOut),
    .dataMemorySuccess(dataMemorySuccess),
    .instructionMemoryReadEnable(instructionMemoryReadEnable),
    .instructionMemoryAddress(instructionMemoryAddress),
    .instructionMemoryDataOut(instructionMemoryDataOut),
    .instructionMemorySuccess(instructionMemorySuccess),
    .button(button),
    .led(led),
    .ledMatrixRow(ledMatrixRow),
    .ledMatrixColumn(ledMatrixColumn)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: run stopped after %0d cycles", cycleCount);
      $display("Simulation failed");
      $finish;
    end
  end

  // What the processor should see for a read, from the memory map rules
  function automatic memWord expectedRead(input bit isInstr, input memAddress addr);
    if (!addr[31]) return refRam[addr[11:2]];
    if (isInstr) return '0;
    if (addr == ledAddress) return memWord'(shadowLed);
    if (addr == buttonAddress) return memWord'(buttonModel);
    return '0;
  endfunction

  function automatic int rowNumber(input matrixByte row);
    for (int i = 0; i < 8; i++) begin
      if (row[i]) return i;
    end
    return 0;
  endfunction

  task automatic addWrite(input memAddress addr);
    tableEntry e;
    e.isInstr = dataPort;
    e.op = opWrite;
    e.address = addr;
    e.writeData = $random(seed);
    e.expected = e.writeData;
    if (addr == ledAddress) begin
      shadowLed = e.writeData[5:0];
      e.expected = memWord'(shadowLed);
    end else if (addr == matrixLowAddress) begin
      for (int i = 0; i < 4; i++) begin
        expectedRows[i] = e.writeData[i*8 +: 8];
      end
    end else if (addr == matrixHighAddress) begin
      for (int i = 0; i < 4; i++) begin
        expectedRows[i+4] = e.writeData[i*8 +: 8];
      end
    end else if (!addr[31]) begin
      refRam[addr[11:2]] = e.writeData;
    end
    entries.push_back(e);
  endtask

  task automatic addRead(input bit isInstr, input memAddress addr);
    tableEntry e;
    e.isInstr = isInstr;
    e.op = opRead;
    e.address = addr;
    e.writeData = '0;
    e.expected = expectedRead(isInstr, addr);
    entries.push_back(e);
  endtask

  task automatic addButtonRead(input logic level);
    tableEntry e;
    buttonModel = level;
    e.isInstr = dataPort;
    e.op = opButton;
    e.address = buttonAddress;
    e.writeData = memWord'(level);
    e.expected = expectedRead(dataPort, buttonAddress);
    entries.push_back(e);
  endtask

  task automatic buildTable();
    // Writes, then reads that miss once and hit after
    addWrite(32'h104);
    addWrite(32'h108);
    addWrite(32'h10C);
    addWrite(32'h110);
    for (int i = 0; i < 4; i++) begin
      addRead(dataPort, 32'h104 + 4 * i);
      addRead(dataPort, 32'h104 + 4 * i);
    end
    addWrite(32'h104);   // Write hit updates the line
    addRead(dataPort, 32'h104);
    addWrite(32'h164);   // Write miss, no allocation
    addRead(dataPort, 32'h164);
    // Same index, different tags
    addWrite(32'h220);
    addWrite(32'h260);
    for (int i = 0; i < 3; i++) begin
      addRead(dataPort, 32'h220);
      addRead(dataPort, 32'h260);
    end
    // Fetches of data written through the data port
    addWrite(32'h300);
    addWrite(32'h304);
    addRead(instrPort, 32'h300);
    addRead(instrPort, 32'h304);
    addRead(instrPort, 32'h300);
    addRead(instrPort, 32'h108);
    addRead(instrPort, ledAddress);
    addRead(instrPort, buttonAddress);
    // Peripherals
    addWrite(ledAddress);
    addRead(dataPort, ledAddress);
    addButtonRead(1'b1);
    addButtonRead(1'b0);
    addButtonRead(1'b1);
    addWrite(matrixLowAddress);
    addWrite(matrixHighAddress);
  endtask

  task automatic waitForSuccess(input bit isInstr, output bit seen, output memWord value);
    int cycles;
    seen = 1'b0;
    value = '0;
    cycles = 0;
    while (!seen && cycles < accessLimit) begin
      @(negedge clk);
      if (isInstr ? instructionMemorySuccess : dataMemorySuccess) begin
        seen = 1'b1;
        value = isInstr ? instructionMemoryDataOut : dataMemoryDataOut;
      end
      cycles++;
    end
  endtask

  task automatic applyEntry(input tableEntry e);
    bit seen;
    memWord value;
    string portName;
    portName = e.isInstr ? "instruction" : "data";
    if (e.op == opButton) begin
      button = e.writeData[0];
      repeat (buttonHold) @(posedge clk);
      #1;
    end
    if (e.isInstr) begin
      instructionMemoryAddress = e.address;
      instructionMemoryReadEnable = 1'b1;
    end else begin
      dataMemoryAddress = e.address;
      dataMemoryDataIn = e.writeData;
      dataMemoryWriteEnable = (e.op == opWrite);
      dataMemoryReadEnable = (e.op != opWrite);
    end
    waitForSuccess(e.isInstr, seen, value);
    @(posedge clk);
    #1;
    instructionMemoryReadEnable = 1'b0;
    dataMemoryReadEnable = 1'b0;
    dataMemoryWriteEnable = 1'b0;
    assert (seen) else begin
      otherErrors++;
      $display("No success from the %s port for address %h within %0d cycles at time %0t",
               portName, e.address, accessLimit, $time);
    end
    if (seen && e.op != opWrite) begin
      assert (value === e.expected) else begin
        valueErrors++;
        $display("FAILED at time %0t: %s read of %h returned %h, expected %h",
                 $time, portName, e.address, value, e.expected);
      end
    end
    if (seen && e.op == opWrite && e.address == ledAddress) begin
      assert (led === e.expected[5:0]) else begin
        valueErrors++;
        $display("FAILED at time %0t: led is %h, expected %h", $time, led, e.expected[5:0]);
      end
    end
    @(posedge clk);   // One idle cycle between accesses
    #1;
  endtask

  task automatic checkResetState();
    @(negedge clk);
    assert (instructionMemorySuccess === 1'b0 && dataMemorySuccess === 1'b0) else begin
      valueErrors++;
      $display("FAILED at time %0t: success high after reset", $time);
    end
    assert (led === '0) else begin
      valueErrors++;
      $display("FAILED at time %0t: led is %h after reset", $time, led);
    end
    assert (ledMatrixRow === 8'h01 && ledMatrixColumn === 8'h00) else begin
      valueErrors++;
      $display("FAILED at time %0t: matrix row %b column %h after reset",
               $time, ledMatrixRow, ledMatrixColumn);
    end
    @(posedge clk);
    #1;
  endtask

  // Three full scans of the eight rows
  task automatic checkMatrixScan();
    int row;
    int lastRow;
    int changes;
    lastRow = -1;
    changes = 0;
    repeat (8 * scanCycles * 3) begin
      @(negedge clk);
      assert ($onehot(ledMatrixRow)) else begin
        valueErrors++;
        $display("FAILED at time %0t: row select %b is not one-hot", $time, ledMatrixRow);
      end
      row = rowNumber(ledMatrixRow);
      assert (ledMatrixColumn === expectedRows[row]) else begin
        valueErrors++;
        $display("FAILED at time %0t: row %0d column %h, expected %h",
                 $time, row, ledMatrixColumn, expectedRows[row]);
      end
      if (lastRow >= 0 && row != lastRow) begin
        changes++;
        assert (row == (lastRow + 1) % 8) else begin
          valueErrors++;
          $display("FAILED at time %0t: row %0d followed row %0d", $time, row, lastRow);
        end
      end
      lastRow = row;
    end
    assert (changes >= 8 * 3 - 1) else begin
      otherErrors++;
      $display("Matrix scan advanced only %0d times in three scan periods", changes);
    end
  endtask

  initial begin
    rst = 1'b1;
    dataMemoryWriteEnable = 1'b0;
    dataMemoryReadEnable = 1'b0;
    dataMemoryAddress = '0;
    dataMemoryDataIn = '0;
    instructionMemoryReadEnable = 1'b0;
    instructionMemoryAddress = '0;
    button = 1'b0;
    seed = 50;
    shadowLed = '0;
    buttonModel = 1'b0;
    for (int i = 0; i < 8; i++) begin
      expectedRows[i] = '0;
    end
    buildTable();
    cycleLimit = entries.size() * 10 + 8 * scanCycles * 3 + resetCycles;
    repeat (resetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
    checkResetState();
    foreach (entries[i]) begin
      applyEntry(entries[i]);
    end
    checkMatrixScan();
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* Mmu.f */
logic/mmuPkg.sv
logic/memoryBus.sv
logic/LedMatrixDriver.sv
logic/CacheL1.sv
logic/MemoryHandler.sv
logic/Mmu.sv
verification/MmuTb.sv

/* Bender.yml */
package:
  name: mmu

sources:
  - logic/mmuPkg.sv
  - logic/memoryBus.sv
  - logic/LedMatrixDriver.sv
  - logic/CacheL1.sv
  - logic/MemoryHandler.sv
  - logic/Mmu.sv
  - target: test
    files:
      - verification/MmuTb.sv
